// ==== compile.f ====
hdl/msx_slot_pkg.sv
hdl/slot_expander.sv
hdl/ram_mapper.sv
hdl/mfrsd3_mapper.sv
hdl/slot_decoder.sv
hdl/msx_slots.sv
test/tb_msx_slots.sv

// ==== test/tb_msx_slots.sv ====
`timescale 1ns/1ps

module tb_msx_slots;

   localparam int PERIOD       = 100;
   localparam int RESET_CYCLES = 10;
   localparam int RUN_CYCLES   = 4000;

   logic                      clk;
   logic                      reset;
   msx_slot_pkg::cpu_bus_t    cpu;
   logic [1:0]                active_slot;
   logic [3:0]                expander_en;
   msx_slot_pkg::block_t      slot_layout [msx_slot_pkg::LAYOUT_ENTRIES];
   msx_slot_pkg::ram_region_t regions [msx_slot_pkg::REGION_ENTRIES];
   logic [1:0]                sdram_size;
   logic [7:0]                ram_dout;
   logic [7:0]                cpu_din;
   msx_slot_pkg::mem_req_t    mem;

   // model copies of subslot, ram mapper and bank registers
   logic [7:0] m_sub [4];
   logic [7:0] m_page [4];
   logic [7:0] m_bank [4];

   logic [31:0]            lfsr = 32'ha3fb_64f7;
   logic [7:0]             exp_din;
   msx_slot_pkg::mem_req_t exp_mem;
   string                  test_name;
   int                     err_din;
   int                     err_mem;

   msx_slots msx_slots_inst (.*);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // fibonacci lfsr with taps 32 22 2 1
   // stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic logic expander_hit_now();
      return cpu.mreq && cpu.addr == msx_slot_pkg::EXPANDER_ADDR && expander_en[active_slot];
   endfunction

   // io ports fc to ff outside interrupt acknowledge
   function automatic logic mapper_port_now();
      return cpu.iorq && !cpu.m1 && cpu.addr[7:2] == 6'h3F;
   endfunction

   // layout entry picked by slot, subslot and page
   function automatic msx_slot_pkg::block_t current_block();
      logic [1:0] page;
      logic [1:0] sub;
      page = cpu.addr[15:14];
      sub  = m_sub[active_slot][2 * page +: 2];
      return slot_layout[{active_slot, sub, page}];
   endfunction

   task automatic randomize_tables();
      for (int i = 0; i < msx_slot_pkg::LAYOUT_ENTRIES; i++) begin
         slot_layout[i].ref_ram    = rand_bits(4);
         slot_layout[i].offset_ram = rand_bits(2);
         slot_layout[i].cart_num   = rand_bits(1);
         slot_layout[i].mapper     = msx_slot_pkg::mapper_t'(rand_bits(8) % 6);
      end
      // sizes are powers of two from 1 to 128 pages of 16 kB
      for (int i = 0; i < msx_slot_pkg::REGION_ENTRIES; i++) begin
         regions[i].base = rand_bits(27);
         regions[i].size = 16'd1 << rand_bits(3);
         regions[i].ro   = rand_bits(2) == 2'd0;
      end
   endtask

   task automatic drive_cycle();
      logic [2:0] kind;
      kind        = rand_bits(3);
      cpu.addr    = rand_bits(16);
      cpu.dout    = rand_bits(8);
      cpu.wr      = rand_bits(1);
      cpu.rd      = ~cpu.wr;
      cpu.mreq    = 1'b1;
      cpu.iorq    = 1'b0;
      cpu.m1      = 1'b0;
      test_name   = "memory";
      case (kind)
         3'd0, 3'd1: begin
            cpu.addr  = msx_slot_pkg::EXPANDER_ADDR;
            test_name = "expander";
         end
         3'd2: begin
            // io cycle aimed at the mapper ports most of the time
            // an int ack now and then
            cpu.mreq      = 1'b0;
            cpu.iorq      = 1'b1;
            cpu.m1        = rand_bits(3) == 3'd0;
            if (rand_bits(2) != 2'd0)
               cpu.addr[7:2] = 6'h3F;
            test_name     = "ram_mapper";
         end
         3'd3: begin
            cpu.addr[15:13] = 3'd3;
            test_name       = "mfrsd3";
         end
         3'd7: begin
            cpu.mreq  = 1'b0;
            cpu.rd    = 1'b0;
            cpu.wr    = 1'b0;
            test_name = "idle";
         end
         default: ;
      endcase
      active_slot = rand_bits(2);
      expander_en = rand_bits(4);
      sdram_size  = rand_bits(2);
      ram_dout    = rand_bits(8);
   endtask

   task automatic predict();
      msx_slot_pkg::block_t      blk;
      msx_slot_pkg::ram_region_t rgn;
      logic [1:0]                page;
      logic [1:0]                rel;
      logic [1:0]                bsel;
      logic [7:0]                seg;
      logic [29:0]               span;
      logic [26:0]               off;
      logic                      unused;
      logic                      unm;
      logic                      acc;
      blk    = current_block();
      rgn    = regions[blk.ref_ram];
      page   = cpu.addr[15:14];
      unused = blk.mapper == msx_slot_pkg::mapper_unused;
      // mfrsd3 window is 4000-bfff only
      unm    = blk.mapper == msx_slot_pkg::mapper_mfrsd3 && (page == 2'd0 || page == 2'd3);
      rel    = page - blk.offset_ram;
      bsel   = cpu.addr[15:13] - 3'd2;
      seg    = m_page[page] & (rgn.size[7:0] - 8'd1);
      span   = rgn.size * 30'd16384 - 30'd1;
      case (blk.mapper)
         msx_slot_pkg::mapper_none:   off = blk.offset_ram * 16384 + cpu.addr[13:0];
         msx_slot_pkg::mapper_ram:    off = seg * 16384 + cpu.addr[13:0];
         msx_slot_pkg::mapper_linear: off = cpu.addr & span;
         msx_slot_pkg::mapper_offset: off = rel * 16384 + cpu.addr[13:0];
         msx_slot_pkg::mapper_mfrsd3: off = m_bank[bsel][6:0] * 8192 + cpu.addr[12:0];
         default:                     off = msx_slot_pkg::UNMAPPED_ADDR;
      endcase
      if (unm)
         off = msx_slot_pkg::UNMAPPED_ADDR;
      // read data priority
      if (mapper_port_now() && cpu.rd)
         exp_din = m_page[cpu.addr[1:0]];
      else if (expander_hit_now() && cpu.rd)
         exp_din = ~m_sub[active_slot];
      else if (unused || unm)
         exp_din = 8'hFF;
      else
         exp_din = ram_dout;
      acc              = cpu.mreq && (cpu.rd || (cpu.wr && !rgn.ro)) && !unused;
      exp_mem.addr     = rgn.base + off;
      exp_mem.din      = cpu.dout;
      exp_mem.rnw      = cpu.rd;
      exp_mem.sdram_ce = acc && sdram_size != 2'd0;
      exp_mem.bram_ce  = acc && sdram_size == 2'd0;
   endtask

   task automatic check_outputs();
      predict();
      assert (cpu_din === exp_din) else begin
         err_din++;
         $display("ERROR %s cpu_din expected %h actual %h", test_name, exp_din, cpu_din);
      end
      assert (mem === exp_mem) else begin
         err_mem++;
         $display("ERROR %s mem expected %h actual %h", test_name, exp_mem, mem);
      end
   endtask

   // register copies step on the rising edge like the dut
   always @(posedge clk or posedge reset) begin : model_update
      msx_slot_pkg::block_t blk;
      blk = current_block();
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            m_sub[i] <= 8'd0;
         end
         m_page[0] <= 8'd3;
         m_page[1] <= 8'd2;
         m_page[2] <= 8'd1;
         m_page[3] <= 8'd0;
         m_bank[0] <= 8'd0;
         m_bank[1] <= 8'd0;
         m_bank[2] <= 8'd1;
         m_bank[3] <= 8'd0;
      end else begin
         if (expander_hit_now() && cpu.wr)
            m_sub[active_slot] <= cpu.dout;
         if (mapper_port_now() && cpu.wr)
            m_page[cpu.addr[1:0]] <= cpu.dout;
         // bank registers at 6000-7fff of an mfrsd3 page
         if (blk.mapper == msx_slot_pkg::mapper_mfrsd3 && cpu.mreq && cpu.wr &&
             cpu.addr[15:13] == 3'd3)
            m_bank[cpu.addr[12:11]] <= cpu.dout;
      end
   end

   // whole run plus 50 cycles of margin
   initial begin
      #((RESET_CYCLES + RUN_CYCLES + 50) * PERIOD);
      $display("watchdog expired before the stimulus loop finished");
      $display("Test FAILED");
      $finish;
   end

   initial begin
      reset       = 1'b1;
      cpu         = '0;
      active_slot = 2'd0;
      expander_en = 4'd0;
      sdram_size  = 2'd0;
      ram_dout    = 8'd0;
      err_din     = 0;
      err_mem     = 0;
      test_name   = "reset";
      for (int i = 0; i < msx_slot_pkg::LAYOUT_ENTRIES; i++)
         slot_layout[i] = '0;
      for (int i = 0; i < msx_slot_pkg::REGION_ENTRIES; i++)
         regions[i] = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      for (int n = 0; n < RUN_CYCLES; n++) begin
         @(negedge clk);
         if (n == 0) begin
            // tables drawn once
            // bus left idle to see reset outputs
            reset = 1'b0;
            randomize_tables();
            test_name = "idle";
         end else begin
            drive_cycle();
         end
         // sample late in the low phase
         #(PERIOD / 2 - 10);
         check_outputs();
      end
      $display("errors: cpu_din %0d, mem %0d", err_din, err_mem);
      if (err_din + err_mem == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== hdl/msx_slots.sv ====
`timescale 1ns/1ps

module msx_slots (
   input  logic                      clk,
   input  logic                      reset,
   input  msx_slot_pkg::cpu_bus_t    cpu,
   input  logic [1:0]                active_slot,
   input  logic [3:0]                expander_en,
   input  msx_slot_pkg::block_t      slot_layout [msx_slot_pkg::LAYOUT_ENTRIES],
   input  msx_slot_pkg::ram_region_t regions [msx_slot_pkg::REGION_ENTRIES],
   input  logic [1:0]                sdram_size,
   input  logic [7:0]                ram_dout,
   output logic [7:0]                cpu_din,
   output msx_slot_pkg::mem_req_t    mem
);

   // expander to decoder
   logic [3:0][7:0] subslot_regs;
   logic            expander_hit;
   logic [7:0]      expander_dout;

   // decoder to mappers
   logic            mfrsd3_cs;
   logic [7:0]      ram_size;

   // mappers back to decoder
   logic [21:0]     ram_offset;
   logic [7:0]      mapper_dout;
   logic            mapper_req;
   logic [19:0]     bank_addr;
   logic            unmapped;

   slot_expander slot_expander_inst (
      .clk           (clk),
      .reset         (reset),
      .cpu           (cpu),
      .active_slot   (active_slot),
      .expander_en   (expander_en),
      .subslot_regs  (subslot_regs),
      .expander_hit  (expander_hit),
      .expander_dout (expander_dout)
   );

   ram_mapper ram_mapper_inst (
      .clk         (clk),
      .reset       (reset),
      .cpu         (cpu),
      .ram_size    (ram_size),
      .ram_offset  (ram_offset),
      .mapper_dout (mapper_dout),
      .mapper_req  (mapper_req)
   );

   mfrsd3_mapper mfrsd3_mapper_inst (
      .clk       (clk),
      .reset     (reset),
      .cs        (mfrsd3_cs),
      .cpu       (cpu),
      .bank_addr (bank_addr),
      .unmapped  (unmapped)
   );

   slot_decoder slot_decoder_inst (
      .cpu           (cpu),
      .active_slot   (active_slot),
      .subslot_regs  (subslot_regs),
      .expander_hit  (expander_hit),
      .expander_dout (expander_dout),
      .slot_layout   (slot_layout),
      .regions       (regions),
      .sdram_size    (sdram_size),
      .ram_dout      (ram_dout),
      .ram_offset    (ram_offset),
      .mapper_dout   (mapper_dout),
      .mapper_req    (mapper_req),
      .bank_addr     (bank_addr),
      .unmapped      (unmapped),
      .mfrsd3_cs     (mfrsd3_cs),
      .ram_size      (ram_size),
      .cpu_din       (cpu_din),
      .mem           (mem)
   );

endmodule

// ==== hdl/slot_decoder.sv ====
`timescale 1ns/1ps

module slot_decoder (
   input  msx_slot_pkg::cpu_bus_t    cpu,
   input  logic [1:0]                active_slot,
   input  logic [3:0][7:0]           subslot_regs,
   input  logic                      expander_hit,
   input  logic [7:0]                expander_dout,
   input  msx_slot_pkg::block_t      slot_layout [msx_slot_pkg::LAYOUT_ENTRIES],
   input  msx_slot_pkg::ram_region_t regions [msx_slot_pkg::REGION_ENTRIES],
   input  logic [1:0]                sdram_size,
   input  logic [7:0]                ram_dout,
   input  logic [21:0]               ram_offset,
   input  logic [7:0]                mapper_dout,
   input  logic                      mapper_req,
   input  logic [19:0]               bank_addr,
   input  logic                      unmapped,
   output logic                      mfrsd3_cs,
   output logic [7:0]                ram_size,
   output logic [7:0]                cpu_din,
   output msx_slot_pkg::mem_req_t    mem
);

   logic [1:0]                      page;
   logic [1:0]                      subslot;
   logic [5:0]                      layout_idx;
   msx_slot_pkg::block_t            block;
   msx_slot_pkg::ram_region_t       region;
   logic                            is_unused;
   logic [29:0]                     lin_mask;
   logic [15:0]                     offset_page;
   logic [msx_slot_pkg::MEM_AW-1:0] none_addr;
   logic [msx_slot_pkg::MEM_AW-1:0] linear_addr;
   logic [msx_slot_pkg::MEM_AW-1:0] offset_addr;
   logic [msx_slot_pkg::MEM_AW-1:0] mapper_addr;
   logic                            access;

   // 16 kB page of the cpu address
   assign page = cpu.addr[15:14];

   // subslot field of the active slot for this page
   assign subslot = subslot_regs[active_slot][{page, 1'b0} +: 2];

   // slot, subslot, page
   assign layout_idx = {active_slot, subslot, page};
   assign block      = slot_layout[layout_idx];
   assign region     = regions[block.ref_ram];

   assign is_unused = block.mapper == msx_slot_pkg::mapper_unused;

   // mapper side channels
   assign mfrsd3_cs = block.mapper == msx_slot_pkg::mapper_mfrsd3;
   assign ram_size  = region.size[7:0];

   // plain rom or ram, fixed page offset
   assign none_addr = {11'd0, block.offset_ram, cpu.addr[13:0]};

   // region size times 16 kB, minus one
   assign lin_mask    = {region.size, 14'd0} - 30'd1;
   assign linear_addr = {11'd0, cpu.addr} & lin_mask[msx_slot_pkg::MEM_AW-1:0];

   // region starts at page offset_ram of the cpu space
   assign offset_page = {page - block.offset_ram, cpu.addr[13:0]};
   assign offset_addr = {11'd0, offset_page};

   always_comb begin
      if (unmapped) begin
         mapper_addr = msx_slot_pkg::UNMAPPED_ADDR;
      end else begin
         case (block.mapper)
            msx_slot_pkg::mapper_none:   mapper_addr = none_addr;
            msx_slot_pkg::mapper_ram:    mapper_addr = {5'd0, ram_offset};
            msx_slot_pkg::mapper_linear: mapper_addr = linear_addr;
            msx_slot_pkg::mapper_offset: mapper_addr = offset_addr;
            msx_slot_pkg::mapper_mfrsd3: mapper_addr = {7'd0, bank_addr};
            default:                     mapper_addr = msx_slot_pkg::UNMAPPED_ADDR;
         endcase
      end
   end

   // writes to read-only regions are dropped
   assign access = cpu.mreq & (cpu.rd | (cpu.wr & ~region.ro)) & ~is_unused;

   // no sdram fitted means everything sits in block ram
   always_comb begin
      mem.addr     = region.base + mapper_addr;
      mem.din      = cpu.dout;
      mem.rnw      = cpu.rd;
      mem.sdram_ce = access & (sdram_size != 2'd0);
      mem.bram_ce  = access & (sdram_size == 2'd0);
   end

   // read data source, first match wins
   // io mapper ports beat the expander register
   always_comb begin
      if (mapper_req) begin
         cpu_din = mapper_dout;
      end else if (expander_hit & cpu.rd) begin
         cpu_din = expander_dout;
      end else if (is_unused | unmapped) begin
         // open bus
         cpu_din = 8'hFF;
      end else begin
         cpu_din = ram_dout;
      end
   end

endmodule

// ==== hdl/mfrsd3_mapper.sv ====
`timescale 1ns/1ps

module mfrsd3_mapper (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cs,
   input  msx_slot_pkg::cpu_bus_t cpu,
   output logic [19:0]            bank_addr,
   output logic                   unmapped
);

   // four 8 kB bank registers
   logic [3:0][7:0] banks;

   logic       bank_wr;
   logic [2:0] range_8k;
   logic [1:0] bank_sel;
   logic       in_window;

   // 8 kB range number of the cpu address
   assign range_8k = cpu.addr[15:13];

   // bank registers decode over 6000-7fff
   // addr 12:11 picks the register
   assign bank_wr = cs & cpu.mreq & cpu.wr & (range_8k == 3'd3);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         banks[0] <= 8'd0;
         banks[1] <= 8'd0;
         banks[2] <= 8'd1;
         banks[3] <= 8'd0;
      end else begin
         if (bank_wr) begin
            banks[cpu.addr[12:11]] <= cpu.dout;
         end
      end
   end

   // 4000 -> bank 0 up to a000 -> bank 3
   assign bank_sel = range_8k[1:0] - 2'd2;

   // top bit of the bank register is not an address bit
   assign bank_addr = {banks[bank_sel][6:0], cpu.addr[12:0]};

   // rom window is pages 1 and 2 only
   assign in_window = (cpu.addr[15:14] == 2'b01) | (cpu.addr[15:14] == 2'b10);
   assign unmapped  = cs & ~in_window;

endmodule

// ==== hdl/ram_mapper.sv ====
`timescale 1ns/1ps

module ram_mapper (
   input  logic                   clk,
   input  logic                   reset,
   input  msx_slot_pkg::cpu_bus_t cpu,
   input  logic [7:0]             ram_size,
   output logic [21:0]            ram_offset,
   output logic [7:0]             mapper_dout,
   output logic                   mapper_req
);

   // one segment register per 16 kB cpu page
   logic [3:0][7:0] pages;

   logic       io_cycle;
   logic       port_hit;
   logic [1:0] port_sel;
   logic [1:0] cur_page;
   logic [7:0] seg_mask;
   logic [7:0] segment;

   // io cycle without interrupt acknowledge
   assign io_cycle = cpu.iorq & ~cpu.m1;

   // ports fc to ff, low two bits pick the page
   assign port_hit = io_cycle & (cpu.addr[7:2] == 6'b111111);
   assign port_sel = cpu.addr[1:0];

   // power-on layout mirrors the bios default
   // page 0 on segment 3 down to page 3 on segment 0
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pages[0] <= 8'd3;
         pages[1] <= 8'd2;
         pages[2] <= 8'd1;
         pages[3] <= 8'd0;
      end else begin
         if (port_hit & cpu.wr) begin
            pages[port_sel] <= cpu.dout;
         end
      end
   end

   // read back of the addressed port
   assign mapper_req  = port_hit & cpu.rd;
   assign mapper_dout = pages[port_sel];

   // segment of the page being accessed
   assign cur_page = cpu.addr[15:14];

   // ram_size is a power of two
   // size minus one folds segments beyond the installed ram
   assign seg_mask = ram_size - 8'd1;
   assign segment  = pages[cur_page] & seg_mask;

   // segment times 16 kB plus offset inside the page
   assign ram_offset = {segment, cpu.addr[13:0]};

endmodule

// ==== hdl/slot_expander.sv ====
`timescale 1ns/1ps

module slot_expander (
   input  logic                   clk,
   input  logic                   reset,
   input  msx_slot_pkg::cpu_bus_t cpu,
   input  logic [1:0]             active_slot,
   input  logic [3:0]             expander_en,
   output logic [3:0][7:0]        subslot_regs,
   output logic                   expander_hit,
   output logic [7:0]             expander_dout
);

   logic addr_match;
   logic slot_expanded;
   logic reg_wr;

   // register lives at the top byte of the address space
   assign addr_match = cpu.addr == msx_slot_pkg::EXPANDER_ADDR;

   // only expanded primary slots answer at ffff
   assign slot_expanded = expander_en[active_slot];

   // memory cycle only, io at ffff is not ours
   assign expander_hit = addr_match & cpu.mreq & slot_expanded;

   assign reg_wr = expander_hit & cpu.wr;

   // one select byte per primary slot
   // two bits per page, page 0 in bits 1:0
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         subslot_regs <= '0;
      end else begin
         if (reg_wr) begin
            subslot_regs[active_slot] <= cpu.dout;
         end
      end
   end

   // msx reads the select register back inverted
   // software uses this to detect an expander
   assign expander_dout = ~subslot_regs[active_slot];

endmodule

// ==== hdl/msx_slot_pkg.sv ====
package msx_slot_pkg;

   // physical memory address width
   localparam int MEM_AW = 27;

   // layout table is slot x subslot x page
   localparam int LAYOUT_ENTRIES = 64;
   localparam int REGION_ENTRIES = 16;

   // secondary slot select register
   localparam logic [15:0] EXPANDER_ADDR = 16'hFFFF;

   // substituted when nothing maps
   localparam logic [MEM_AW-1:0] UNMAPPED_ADDR = 27'h000DEAD;

   typedef enum logic [2:0] {
      mapper_unused,
      mapper_none,
      mapper_ram,
      mapper_linear,
      mapper_offset,
      mapper_mfrsd3
   } mapper_t;

   // one z80 bus cycle, dout is cpu to memory
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        wr;
      logic        rd;
      logic        mreq;
      logic        iorq;
      logic        m1;
   } cpu_bus_t;

   // one layout entry per 16 kB page
   typedef struct packed {
      logic [3:0] ref_ram;
      logic [1:0] offset_ram;
      logic       cart_num;
      mapper_t    mapper;
   } block_t;

   // size counted in 16 kB units
   typedef struct packed {
      logic [MEM_AW-1:0] base;
      logic [15:0]       size;
      logic              ro;
   } ram_region_t;

   typedef struct packed {
      logic [MEM_AW-1:0] addr;
      logic [7:0]        din;
      logic              rnw;
      logic              sdram_ce;
      logic              bram_ce;
   } mem_req_t;

endpackage
